// File: lspcPkg.sv
// LSPC shared definitions
// Video timing constants, CPU register offsets and word types
package lspcPkg;

	// ====================================================================
	// Word types
	// ====================================================================

	// CPU bus and VRAM data word
	typedef logic [15:0] cpuWord_t;
	// VRAM word address
	typedef logic [15:0] vramAddr_t;
	// Register word offset on the CPU side
	typedef logic [1:0]  cpuAddr_t;
	// Counters of the sync generator
	typedef logic [8:0]  pixelCount_t;
	typedef logic [8:0]  rasterCount_t;
	// Auto-animation tile index and pacing
	typedef logic [2:0]  aaCount_t;
	typedef logic [7:0]  aaSpeed_t;

	// ====================================================================
	// Video timing
	// ====================================================================

	// 6 MHz pixel clocks per line, lines per frame
	localparam int unsigned PixelsPerLine    = 384;
	localparam int unsigned LinesPerFrame    = 264;
	// Sync pulse widths, counted from line / frame start
	localparam int unsigned HSyncPixels      = 28;
	localparam int unsigned VSyncLines       = 8;
	// Active window, inclusive bounds
	localparam int unsigned ActiveFirstPixel = 30;
	localparam int unsigned ActiveLastPixel  = 349;
	localparam int unsigned ActiveFirstLine  = 16;
	localparam int unsigned ActiveLastLine   = 239;

	// ====================================================================
	// CPU register map (word offsets)
	// ====================================================================

	localparam cpuAddr_t RegVramAddr = 2'd0;
	localparam cpuAddr_t RegVramRw   = 2'd1;
	localparam cpuAddr_t RegVramMod  = 2'd2;
	localparam cpuAddr_t RegLspcMode = 2'd3;

endpackage

// File: lspcClockGen.sv
// LSPC clock divider
// Derives 12/6/3/1.5 MHz one-cycle enables from the 24 MHz master clock
module lspcClockGen (
	input  logic CLK,
	input  logic nRESETP,
	output logic en12m,
	output logic en6m,
	output logic en3m,
	output logic en1m5
);

	// Free-running divider, bit n toggles at CLK / 2^(n+1)
	logic [3:0] divCount;

	always_ff @(posedge CLK or negedge nRESETP) begin
		if (!nRESETP) begin
			divCount <= '0;
		end else begin
			divCount <= divCount + 1'b1;
		end
	end

	// Strobe on the last state of each power-of-two period
	assign en12m = divCount[0];
	assign en6m  = &divCount[1:0];
	assign en3m  = &divCount[2:0];
	assign en1m5 = &divCount;

	// Slower strobes line up with a 12 MHz strobe
	assert property (@(posedge CLK) disable iff (!nRESETP)
		(en6m || en3m || en1m5) |-> en12m);

endmodule

// File: lspcVideoSync.sv
// LSPC video sync generator
// Pixel/raster counters, HSYNC, VSYNC, CHBL, line FLIP and frame-start pulse
module lspcVideoSync (
	input  logic                  CLK,
	input  logic                  nRESETP,
	input  logic                  en6m,
	output logic                  HSYNC,
	output logic                  VSYNC,
	output logic                  CHBL,
	output logic                  FLIP,
	output logic                  frameStart,
	output lspcPkg::pixelCount_t  pixelCount,
	output lspcPkg::rasterCount_t rasterCount
);
	import lspcPkg::*;

	logic lineEnd;
	logic frameEnd;
	logic hActive;
	logic vActive;

	// Last pixel of the line, last line of the frame
	assign lineEnd  = en6m && (pixelCount == pixelCount_t'(PixelsPerLine - 1));
	assign frameEnd = lineEnd && (rasterCount == rasterCount_t'(LinesPerFrame - 1));

	// ====================================================================
	// Counters
	// ====================================================================

	always_ff @(posedge CLK or negedge nRESETP) begin
		if (!nRESETP) begin
			pixelCount <= '0;
		end else if (lineEnd) begin
			pixelCount <= '0;
		end else if (en6m) begin
			pixelCount <= pixelCount + 1'b1;
		end
	end

	// Raster advances on pixel wrap
	always_ff @(posedge CLK or negedge nRESETP) begin
		if (!nRESETP) begin
			rasterCount <= '0;
		end else if (frameEnd) begin
			rasterCount <= '0;
		end else if (lineEnd) begin
			rasterCount <= rasterCount + 1'b1;
		end
	end

	// Buffer select, flips at every new line
	always_ff @(posedge CLK or negedge nRESETP) begin
		if (!nRESETP) begin
			FLIP <= 1'b0;
		end else if (lineEnd) begin
			FLIP <= ~FLIP;
		end
	end

	// ====================================================================
	// Sync and blanking decode
	// ====================================================================

	// Sync pulses are low at the start of line / frame
	assign HSYNC = (pixelCount >= pixelCount_t'(HSyncPixels));
	assign VSYNC = (rasterCount >= rasterCount_t'(VSyncLines));

	assign hActive = (pixelCount >= pixelCount_t'(ActiveFirstPixel))
		&& (pixelCount <= pixelCount_t'(ActiveLastPixel));
	assign vActive = (rasterCount >= rasterCount_t'(ActiveFirstLine))
		&& (rasterCount <= rasterCount_t'(ActiveLastLine));
	// Blank outside either window
	assign CHBL = ~(hActive && vActive);

	// Same cycle as the raster wrap
	assign frameStart = frameEnd;

	// Counters stay inside the line and frame
	assert property (@(posedge CLK) disable iff (!nRESETP)
		pixelCount < pixelCount_t'(PixelsPerLine));
	assert property (@(posedge CLK) disable iff (!nRESETP)
		rasterCount < rasterCount_t'(LinesPerFrame));

endmodule

// File: lspcCpuRegs.sv
// LSPC CPU register block
// Register decode, VRAMMOD/LSPCMODE storage and readback mux
module lspcCpuRegs (
	input  logic                  CLK,
	input  logic                  nRESETP,
	input  lspcPkg::cpuAddr_t     cpuAddr,
	input  lspcPkg::cpuWord_t     cpuWrData,
	input  logic                  cpuWe,
	input  lspcPkg::cpuWord_t     vramRdData,
	input  lspcPkg::rasterCount_t rasterCount,
	input  lspcPkg::aaCount_t     aaCount,
	output lspcPkg::cpuWord_t     cpuRdData,
	output logic                  addrLoad,
	output lspcPkg::vramAddr_t    addrValue,
	output logic                  dataWrite,
	output lspcPkg::cpuWord_t     dataValue,
	output lspcPkg::cpuWord_t     vramMod,
	output lspcPkg::aaSpeed_t     aaSpeed
);
	import lspcPkg::*;

	// ====================================================================
	// Write decode
	// ====================================================================

	// VRAMADDR write, pointer load
	assign addrLoad  = cpuWe && (cpuAddr == RegVramAddr);
	assign addrValue = vramAddr_t'(cpuWrData);

	// VRAMRW write, goes out as a VRAM write
	assign dataWrite = cpuWe && (cpuAddr == RegVramRw);
	assign dataValue = cpuWrData;

	// Stored registers
	always_ff @(posedge CLK or negedge nRESETP) begin
		if (!nRESETP) begin
			vramMod <= '0;
			aaSpeed <= '0;
		end else if (cpuWe) begin
			if (cpuAddr == RegVramMod) begin
				vramMod <= cpuWrData;
			end
			// Only the speed byte of LSPCMODE is kept
			if (cpuAddr == RegLspcMode) begin
				aaSpeed <= cpuWrData[15:8];
			end
		end
	end

	// ====================================================================
	// Read mux
	// ====================================================================

	always_comb begin
		unique case (cpuAddr)
			// Both VRAM offsets read the word at the pointer
			RegVramAddr: cpuRdData = vramRdData;
			RegVramRw:   cpuRdData = vramRdData;
			RegVramMod:  cpuRdData = vramMod;
			// Raster line up top, tile index at the bottom
			RegLspcMode: cpuRdData = {rasterCount, 4'b0000, aaCount};
			default:     cpuRdData = '0;
		endcase
	end

endmodule

// File: lspcVramPort.sv
// LSPC VRAM access port
// Address pointer, registered write strobe and modulo auto-increment
module lspcVramPort (
	input  logic               CLK,
	input  logic               nRESETP,
	input  logic               addrLoad,
	input  lspcPkg::vramAddr_t addrValue,
	input  logic               dataWrite,
	input  lspcPkg::cpuWord_t  dataValue,
	input  lspcPkg::cpuWord_t  vramMod,
	output lspcPkg::vramAddr_t vramAddr,
	output lspcPkg::cpuWord_t  vramWrData,
	output logic               vramWe
);
	import lspcPkg::*;

	vramAddr_t pointer;

	// Pointer drives the memory address directly
	assign vramAddr = pointer;

	// CPU load wins over auto-increment
	// Increment lands at the end of the write cycle, 16-bit wrap
	always_ff @(posedge CLK or negedge nRESETP) begin
		if (!nRESETP) begin
			pointer <= '0;
		end else if (addrLoad) begin
			pointer <= addrValue;
		end else if (vramWe) begin
			pointer <= pointer + vramAddr_t'(vramMod);
		end
	end

	// Write strobe, one CLK after the CPU strobe
	always_ff @(posedge CLK or negedge nRESETP) begin
		if (!nRESETP) begin
			vramWe <= 1'b0;
		end else begin
			vramWe <= dataWrite;
		end
	end

	// Write data captured with the strobe
	always_ff @(posedge CLK) begin
		if (dataWrite) begin
			vramWrData <= dataValue;
		end
	end

	// Back-to-back VRAMRW writes would skip an increment
	assert property (@(posedge CLK) disable iff (!nRESETP)
		vramWe |=> !vramWe);

endmodule

// File: lspcAutoAnim.sv
// LSPC auto-animation counter
// 3-bit tile index advanced every aaSpeed+1 frames
module lspcAutoAnim (
	input  logic              CLK,
	input  logic              nRESETP,
	input  logic              frameStart,
	input  lspcPkg::aaSpeed_t aaSpeed,
	output lspcPkg::aaCount_t aaCount
);
	import lspcPkg::*;

	// Frames left before the next tile step
	aaSpeed_t frameDiv;

	// Reload and step on zero, else count down
	always_ff @(posedge CLK or negedge nRESETP) begin
		if (!nRESETP) begin
			frameDiv <= '0;
			aaCount  <= '0;
		end else if (frameStart) begin
			if (frameDiv == '0) begin
				frameDiv <= aaSpeed;
				// Wraps 7 -> 0
				aaCount  <= aaCount + 1'b1;
			end else begin
				frameDiv <= frameDiv - 1'b1;
			end
		end
	end

endmodule

// File: lspcTop.sv
// LSPC video timing and CPU register top level
// Clock divider, sync generator, registers, VRAM port and auto-animation
module lspcTop (
	input  logic               CLK,
	input  logic               nRESETP,
	input  lspcPkg::cpuAddr_t  cpuAddr,
	input  lspcPkg::cpuWord_t  cpuWrData,
	input  logic               cpuWe,
	input  lspcPkg::cpuWord_t  vramRdData,
	output lspcPkg::cpuWord_t  cpuRdData,
	output lspcPkg::vramAddr_t vramAddr,
	output lspcPkg::cpuWord_t  vramWrData,
	output logic               vramWe,
	output logic               HSYNC,
	output logic               VSYNC,
	output logic               CHBL,
	output logic               FLIP
);
	import lspcPkg::*;

	// Timing
	logic         en6m;
	logic         frameStart;
	rasterCount_t rasterCount;

	// Register block to VRAM port and animation
	logic         addrLoad;
	vramAddr_t    addrValue;
	logic         dataWrite;
	cpuWord_t     dataValue;
	cpuWord_t     vramMod;
	aaSpeed_t     aaSpeed;
	aaCount_t     aaCount;

	// Only the pixel strobe is needed here
	lspcClockGen uClockGen (
		.CLK     (CLK),
		.nRESETP (nRESETP),
		.en12m   (),
		.en6m    (en6m),
		.en3m    (),
		.en1m5   ()
	);

	// Pixel count feeds no block yet
	lspcVideoSync uVideoSync (
		.CLK         (CLK),
		.nRESETP     (nRESETP),
		.en6m        (en6m),
		.HSYNC       (HSYNC),
		.VSYNC       (VSYNC),
		.CHBL        (CHBL),
		.FLIP        (FLIP),
		.frameStart  (frameStart),
		.pixelCount  (),
		.rasterCount (rasterCount)
	);

	lspcCpuRegs uCpuRegs (
		.CLK         (CLK),
		.nRESETP     (nRESETP),
		.cpuAddr     (cpuAddr),
		.cpuWrData   (cpuWrData),
		.cpuWe       (cpuWe),
		.vramRdData  (vramRdData),
		.rasterCount (rasterCount),
		.aaCount     (aaCount),
		.cpuRdData   (cpuRdData),
		.addrLoad    (addrLoad),
		.addrValue   (addrValue),
		.dataWrite   (dataWrite),
		.dataValue   (dataValue),
		.vramMod     (vramMod),
		.aaSpeed     (aaSpeed)
	);

	lspcVramPort uVramPort (
		.CLK        (CLK),
		.nRESETP    (nRESETP),
		.addrLoad   (addrLoad),
		.addrValue  (addrValue),
		.dataWrite  (dataWrite),
		.dataValue  (dataValue),
		.vramMod    (vramMod),
		.vramAddr   (vramAddr),
		.vramWrData (vramWrData),
		.vramWe     (vramWe)
	);

	lspcAutoAnim uAutoAnim (
		.CLK        (CLK),
		.nRESETP    (nRESETP),
		.frameStart (frameStart),
		.aaSpeed    (aaSpeed),
		.aaCount    (aaCount)
	);

endmodule

// File: tbClock.sv
// Testbench clock and reset source
// 10-unit clock, active-low reset held for the first 5 cycles
module tbClock (
	output logic CLK,
	output logic nRESETP
);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	// Release on a rising edge, after 5 full cycles
	initial begin
		nRESETP = 1'b0;
		repeat (5) @(posedge CLK);
		nRESETP <= 1'b1;
	end

endmodule

// File: tbLspc.sv
// LSPC directed testbench
// VRAM model, sync timing, auto-increment writes, readback and auto-animation
module tbLspc;
	import lspcPkg::*;

	// Expected timing in master clocks
	localparam int LineClocks   = 1536;
	localparam int FrameClocks  = 264 * 1536;
	localparam int HSyncClocks  = 28 * 4;
	localparam int VSyncClocks  = 8 * 1536;
	// Unblanked clocks per frame, 224 lines of 320 pixels
	localparam int ActiveClocks = 224 * 320 * 4;
	localparam int SelHsync     = 0;
	localparam int SelVsync     = 1;

	logic      CLK;
	logic      nRESETP;
	cpuAddr_t  cpuAddr;
	cpuWord_t  cpuWrData;
	logic      cpuWe;
	cpuWord_t  vramRdData;
	cpuWord_t  cpuRdData;
	vramAddr_t vramAddr;
	cpuWord_t  vramWrData;
	logic      vramWe;
	logic      HSYNC;
	logic      VSYNC;
	logic      CHBL;
	logic      FLIP;

	cpuWord_t    vram [0:65535];
	cpuWord_t    written [0:7];
	cpuWord_t    modValue;
	vramAddr_t   baseAddr;
	int          cycleCount = 0;
	int          weCount = 0;
	int          flipCount = 0;
	logic        lastFlip = 1'b0;
	int          frameCount = 0;
	logic        lastVsync = 1'b0;
	int          activeCount = 0;
	int          errorCount = 0;
	int          maxRaster = 0;
	logic [31:0] lfsrState = 32'd72098;

	tbClock uClock (.CLK(CLK), .nRESETP(nRESETP));

	lspcTop uut (
		.CLK(CLK), .nRESETP(nRESETP),
		.cpuAddr(cpuAddr), .cpuWrData(cpuWrData), .cpuWe(cpuWe),
		.vramRdData(vramRdData), .cpuRdData(cpuRdData),
		.vramAddr(vramAddr), .vramWrData(vramWrData), .vramWe(vramWe),
		.HSYNC(HSYNC), .VSYNC(VSYNC), .CHBL(CHBL), .FLIP(FLIP)
	);

	// ====================================================================
	// VRAM model and monitors
	// ====================================================================

	// Byte-swapped address fill
	initial begin
		for (int a = 0; a < 65536; a++) begin
			vram[a] = {a[7:0], a[15:8]} ^ 16'h5A3C;
		end
	end

	assign vramRdData = vram[vramAddr];

	always @(posedge CLK) begin
		if (vramWe) begin
			vram[vramAddr] <= vramWrData;
		end
	end

	// Counters seen one edge late, read at the falling edge
	always @(posedge CLK) begin
		cycleCount <= cycleCount + 1;
		lastFlip <= FLIP;
		lastVsync <= VSYNC;
		if (vramWe) begin
			weCount <= weCount + 1;
		end
		if (nRESETP && FLIP !== lastFlip) begin
			flipCount <= flipCount + 1;
		end
		// VSYNC falls on the same edge as the raster wrap
		if (nRESETP && lastVsync === 1'b1 && VSYNC === 1'b0) begin
			frameCount <= frameCount + 1;
		end
		if (nRESETP && CHBL === 1'b0) begin
			activeCount <= activeCount + 1;
		end
	end

	// ====================================================================
	// Helpers
	// ====================================================================

	// 32-bit Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] randomBits(input int width);
		logic [31:0] value;
		logic        fb;
		value = '0;
		for (int i = 0; i < width; i++) begin
			fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
			lfsrState = {lfsrState[30:0], fb};
			value = {value[30:0], fb};
		end
		return value;
	endfunction

	function automatic logic probeSync(input int sel);
		return (sel == SelVsync) ? VSYNC : HSYNC;
	endfunction

	task automatic compareValue(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			errorCount++;
			$display("[ERROR] %s: actual 0x%0h, expected 0x%0h", name, actual, expected);
			$display("Simulation failed");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	task automatic timeoutAbort(input string what);
		$display("Timeout: %s did not happen in time", what);
		$display("Simulation failed");
		$fatal(1, "Timeout on %s", what);
	endtask

	// Raster field is only visible while offset 3 is selected
	task automatic trackRaster();
		if (cpuAddr == RegLspcMode && int'(cpuRdData[15:7]) > maxRaster) begin
			maxRaster = cpuRdData[15:7];
		end
	endtask

	// Sample at falling edges until the sync output reaches level
	task automatic untilLevel(input string what, input int sel, input logic level,
			input int limit);
		int waited;
		waited = 0;
		@(negedge CLK);
		trackRaster();
		while (probeSync(sel) !== level && waited < limit) begin
			@(negedge CLK);
			trackRaster();
			waited++;
		end
		if (probeSync(sel) !== level) begin
			timeoutAbort(what);
		end
	endtask

	task automatic resetRelease();
		int waited;
		waited = 0;
		@(negedge CLK);
		while (nRESETP !== 1'b1 && waited < 20) begin
			@(negedge CLK);
			waited++;
		end
		if (nRESETP !== 1'b1) begin
			timeoutAbort("reset release");
		end
	endtask

	// Pass falling edges, end with VSYNC high again
	task automatic passFrames(input int count);
		repeat (count) begin
			untilLevel("VSYNC fall", SelVsync, 1'b0, FrameClocks + LineClocks);
			untilLevel("VSYNC rise", SelVsync, 1'b1, FrameClocks + LineClocks);
		end
	endtask

	// One-CLK write strobe
	task automatic writeReg(input cpuAddr_t addr, input cpuWord_t data);
		@(posedge CLK);
		cpuAddr <= addr;
		cpuWrData <= data;
		cpuWe <= 1'b1;
		@(posedge CLK);
		cpuWe <= 1'b0;
	endtask

	task automatic readReg(input cpuAddr_t addr, output cpuWord_t data);
		@(posedge CLK);
		cpuAddr <= addr;
		@(negedge CLK);
		data = cpuRdData;
	endtask

	// ====================================================================
	// Directed tests
	// ====================================================================

	task automatic resetStateTest();
		resetRelease();
		compareValue("vramWe", vramWe, 0);
		compareValue("HSYNC", HSYNC, 0);
		compareValue("VSYNC", VSYNC, 0);
		compareValue("CHBL", CHBL, 1);
		compareValue("FLIP", FLIP, 0);
	endtask

	task automatic lineTimingTest();
		int t0;
		int t1;
		int f0;
		untilLevel("HSYNC rise", SelHsync, 1'b1, LineClocks);
		untilLevel("HSYNC fall", SelHsync, 1'b0, LineClocks);
		t0 = cycleCount;
		f0 = flipCount;
		untilLevel("HSYNC rise", SelHsync, 1'b1, LineClocks);
		t1 = cycleCount;
		compareValue("HSYNC low clocks", t1 - t0, HSyncClocks);
		untilLevel("HSYNC fall", SelHsync, 1'b0, LineClocks);
		t1 = cycleCount;
		compareValue("HSYNC period", t1 - t0, LineClocks);
		compareValue("FLIP changes", flipCount - f0, 1);
	endtask

	task automatic frameTimingTest();
		int t0;
		int t1;
		int a0;
		@(posedge CLK);
		cpuAddr <= RegLspcMode;
		maxRaster = 0;
		untilLevel("VSYNC rise", SelVsync, 1'b1, FrameClocks + LineClocks);
		untilLevel("VSYNC fall", SelVsync, 1'b0, FrameClocks + LineClocks);
		t0 = cycleCount;
		a0 = activeCount;
		untilLevel("VSYNC rise", SelVsync, 1'b1, FrameClocks + LineClocks);
		t1 = cycleCount;
		compareValue("VSYNC low clocks", t1 - t0, VSyncClocks);
		untilLevel("VSYNC fall", SelVsync, 1'b0, FrameClocks + LineClocks);
		t1 = cycleCount;
		compareValue("VSYNC period", t1 - t0, FrameClocks);
		compareValue("CHBL low clocks", activeCount - a0, ActiveClocks);
		// Whole frame seen, last line is 263
		compareValue("raster max", maxRaster, 263);
	endtask

	task automatic autoIncrementTest();
		int        we0;
		vramAddr_t addr;
		// Odd modulo keeps the 8 addresses distinct
		modValue = cpuWord_t'(randomBits(16)) | 16'h0001;
		baseAddr = vramAddr_t'(randomBits(16));
		writeReg(RegVramMod, modValue);
		writeReg(RegVramAddr, baseAddr);
		@(negedge CLK);
		we0 = weCount;
		for (int i = 0; i < 8; i++) begin
			written[i] = cpuWord_t'(randomBits(16));
			writeReg(RegVramRw, written[i]);
			// Spacing of 3 CLK between strobes
			@(posedge CLK);
		end
		repeat (3) @(negedge CLK);
		compareValue("vramWe cycles", weCount - we0, 8);
		for (int i = 0; i < 8; i++) begin
			addr = baseAddr + vramAddr_t'(i) * modValue;
			compareValue($sformatf("vram[0x%0h]", addr), vram[addr], written[i]);
		end
	endtask

	task automatic readbackTest();
		cpuWord_t  word;
		vramAddr_t addr;
		readReg(RegVramMod, word);
		compareValue("VRAMMOD", word, modValue);
		addr = baseAddr + 16'd5 * modValue;
		writeReg(RegVramAddr, addr);
		readReg(RegVramAddr, word);
		compareValue("VRAMADDR read", word, written[5]);
		readReg(RegVramRw, word);
		compareValue("VRAMRW read", word, written[5]);
	endtask

	task automatic autoAnimTest();
		cpuWord_t word;
		int       switchFrames;
		int       steps;
		// Speed has been 0 since reset so every frame wrap was a step
		writeReg(RegLspcMode, 16'h0000);
		untilLevel("VSYNC rise", SelVsync, 1'b1, FrameClocks + LineClocks);
		repeat (3) begin
			passFrames(1);
			readReg(RegLspcMode, word);
			compareValue("aaCount speed 0", word[2:0], frameCount % 8);
		end
		// Divider sits at 0, so speed 1 steps on the first wrap and every second one
		writeReg(RegLspcMode, 16'h0100);
		switchFrames = frameCount;
		repeat (2) begin
			passFrames(2);
			readReg(RegLspcMode, word);
			steps = (frameCount - switchFrames + 1) / 2;
			compareValue("aaCount speed 1", word[2:0], (switchFrames + steps) % 8);
		end
	endtask

	// ====================================================================
	// Test sequence
	// ====================================================================

	initial begin
		cpuAddr = RegVramAddr;
		cpuWrData = '0;
		cpuWe = 1'b0;
		resetStateTest();
		lineTimingTest();
		frameTimingTest();
		autoIncrementTest();
		readbackTest();
		autoAnimTest();
		if (errorCount == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// File: build.f
lspcPkg.sv
lspcClockGen.sv
lspcVideoSync.sv
lspcCpuRegs.sv
lspcVramPort.sv
lspcAutoAnim.sv
lspcTop.sv
tbClock.sv
tbLspc.sv

// File: Bender.yml
package:
  name: lspc

sources:
  - lspcPkg.sv
  - lspcClockGen.sv
  - lspcVideoSync.sv
  - lspcCpuRegs.sv
  - lspcVramPort.sv
  - lspcAutoAnim.sv
  - lspcTop.sv
  - target: test
    files:
      - tbClock.sv
      - tbLspc.sv
